// File: design/dtlb_pkg.sv
`default_nettype none

package dtlb_pkg;

    localparam int PAGE_OFFSET_W = 12;
    localparam int VPN_W         = 9;
    localparam int LEVELS        = 3;
    localparam int VPN_ALL_W     = LEVELS * VPN_W;  // 27 bit sv39 vpn
    localparam int PTE_SHIFT     = 3;               // log2 of pte size in bytes
    localparam int PPN_W         = 44;

    typedef logic [63:0]      vaddr_t;
    typedef logic [55:0]      paddr_t;
    typedef logic [PPN_W-1:0] ppn_t;
    typedef logic [VPN_W-1:0] vpn_t;
    typedef logic [63:0]      pte_t;
    typedef logic [63:0]      satp_t;
    typedef logic [1:0]       priv_t;

    // pte flag positions
    localparam int PTE_V       = 0;
    localparam int PTE_R       = 1;
    localparam int PTE_W       = 2;
    localparam int PTE_X       = 3;
    localparam int PTE_A       = 6;
    localparam int PTE_D       = 7;
    localparam int PTE_PPN_LSB = 10;

    localparam int SATP_MODE_LSB = 60;
    localparam int SATP_MODE_W   = 4;

    localparam logic [SATP_MODE_W-1:0] MODE_SV39 = 4'd8;
    localparam priv_t                  PRIV_M    = 2'd3;

    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,
        OP_LOAD  = 2'd1,
        OP_STORE = 2'd2,
        OP_FETCH = 2'd3
    } op_e;

    typedef enum logic [1:0] {
        WALK_IDLE = 2'd0,
        WALK_L2   = 2'd1,
        WALK_L1   = 2'd2,
        WALK_L0   = 2'd3
    } walk_state_e;

    function automatic logic [VPN_ALL_W-1:0] vpn_of(vaddr_t va);
        return va[PAGE_OFFSET_W +: VPN_ALL_W];
    endfunction

    function automatic vpn_t vpn_slice(vaddr_t va, int level);
        return va[PAGE_OFFSET_W + level * VPN_W +: VPN_W];
    endfunction

    // keep at least one tag bit, a full-depth array compares nothing useful
    function automatic int tlb_tag_w(int depth);
        return (VPN_ALL_W > $clog2(depth)) ? VPN_ALL_W - $clog2(depth) : 1;
    endfunction

endpackage

`default_nettype wire

// File: design/tlb_refill_if.sv
`timescale 1ns/10ps
`default_nettype none

interface tlb_refill_if
    import dtlb_pkg::*;
#(
    parameter int TLB_DEPTH = 256
);

    localparam int IDX_W = $clog2(TLB_DEPTH);
    localparam int TAG_W = tlb_tag_w(TLB_DEPTH);

    logic             wr;        // one cycle write strobe
    logic [IDX_W-1:0] index;
    logic [TAG_W-1:0] tag;
    ppn_t             ppn;       // already merged for superpages
    logic             dirty;
    logic             writable;

    modport walker (output wr, index, tag, ppn, dirty, writable);
    modport array  (input  wr, index, tag, ppn, dirty, writable);

endinterface

`default_nettype wire

// File: design/tlb_array.sv
`timescale 1ns/10ps
`default_nettype none

module tlb_array
    import dtlb_pkg::*;
#(
    parameter int TLB_DEPTH = 256
) (
    input  wire logic                               CLK,
    input  wire logic                               RST,
    input  wire logic                               flush,
    input  wire logic [$clog2(TLB_DEPTH)-1:0]       rd_index,
    output logic      [tlb_tag_w(TLB_DEPTH)-1:0]    rd_tag,
    output ppn_t                                    rd_ppn,
    output logic                                    rd_dirty,
    output logic                                    rd_writable,
    output logic                                    rd_valid,
    tlb_refill_if.array                             refill
);

    localparam int IDX_W   = $clog2(TLB_DEPTH);
    localparam int TAG_W   = tlb_tag_w(TLB_DEPTH);
    localparam int ENTRY_W = TAG_W + PPN_W + 2;

    logic [ENTRY_W-1:0]   entry_mem [TLB_DEPTH];
    logic [ENTRY_W-1:0]   rd_entry;
    logic [TLB_DEPTH-1:0] valid_q;   // flops, so a flush clears all entries at once

    // entry word is {tag, ppn, dirty, writable}
    always_ff @(posedge CLK) begin
        if (refill.wr) begin
            entry_mem[refill.index] <= {refill.tag, refill.ppn, refill.dirty, refill.writable};
        end
        rd_entry <= entry_mem[rd_index];
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            valid_q  <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (flush) begin
                valid_q <= '0;              // flush wins over a refill
            end else if (refill.wr) begin
                valid_q[refill.index] <= 1'b1;
            end
            rd_valid <= valid_q[rd_index];
        end
    end

    assign rd_tag      = rd_entry[ENTRY_W-1 -: TAG_W];
    assign rd_ppn      = rd_entry[2 +: PPN_W];
    assign rd_dirty    = rd_entry[1];
    assign rd_writable = rd_entry[0];

endmodule

`default_nettype wire

// File: design/translate_stage.sv
`timescale 1ns/10ps
`default_nettype none

module translate_stage
    import dtlb_pkg::*;
#(
    parameter int TLB_DEPTH = 256
) (
    input  wire logic                               CLK,
    input  wire logic                               RST,
    input  wire logic                               flush,

    input  wire logic                               req_valid,
    output logic                                    req_ready,
    input  wire vaddr_t                             req_vaddr,
    input  wire op_e                                req_op,
    input  wire satp_t                              satp,
    input  wire priv_t                              priv,
    output logic                                    resp_valid,
    input  wire logic                               resp_ready,
    output paddr_t                                  resp_paddr,
    output logic                                    resp_fault,
    output op_e                                     resp_fault_op,

    output logic      [$clog2(TLB_DEPTH)-1:0]       rd_index,
    input  wire logic [tlb_tag_w(TLB_DEPTH)-1:0]    rd_tag,
    input  wire ppn_t                               rd_ppn,
    input  wire logic                               rd_dirty,
    input  wire logic                               rd_writable,
    input  wire logic                               rd_valid,

    output logic                                    walk_start,
    output vaddr_t                                  walk_vaddr,
    output op_e                                     walk_op,
    output ppn_t                                    walk_root,
    input  wire logic                               walk_done,
    input  wire logic                               walk_fault,
    input  wire ppn_t                               walk_ppn
);

    localparam int IDX_W = $clog2(TLB_DEPTH);
    localparam int TAG_W = tlb_tag_w(TLB_DEPTH);

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_CHECK = 2'd1,   // array data valid this cycle
        ST_WALK  = 2'd2,
        ST_RESP  = 2'd3
    } stage_e;

    stage_e state_q;

    vaddr_t vaddr_q;
    op_e    op_q;
    ppn_t   root_q;
    logic   off_q;

    paddr_t paddr_q;
    logic   fault_q;
    op_e    fault_op_q;

    logic             accept;
    logic             req_off;
    logic [TAG_W-1:0] req_tag;
    logic             tag_hit;
    logic             perm_fault;
    logic             check_done;

    assign req_ready = (state_q == ST_IDLE) & ~flush;
    assign accept    = req_valid & req_ready;

    // op none, bare mode or machine mode all bypass
    assign req_off = (req_op == OP_NONE)
                   | (satp[SATP_MODE_LSB +: SATP_MODE_W] != MODE_SV39)
                   | (priv == PRIV_M);

    assign rd_index = IDX_W'(vpn_of(req_vaddr));   // read fires on the accepting edge

    assign req_tag    = TAG_W'(vpn_of(vaddr_q) >> IDX_W);
    assign tag_hit    = rd_valid & (rd_tag == req_tag);
    assign perm_fault = (op_q == OP_STORE) & ~(rd_dirty & rd_writable);
    assign check_done = off_q | tag_hit;

    assign walk_start = (state_q == ST_CHECK) & ~check_done;
    assign walk_vaddr = vaddr_q;
    assign walk_op    = op_q;
    assign walk_root  = root_q;

    always_ff @(posedge CLK) begin
        if (RST) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE:  if (accept) state_q <= ST_CHECK;
                ST_CHECK: state_q <= check_done ? ST_RESP : ST_WALK;
                ST_WALK:  if (walk_done) state_q <= ST_RESP;
                ST_RESP:  if (resp_ready) state_q <= ST_IDLE;
                default:  state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            vaddr_q <= req_vaddr;
            op_q    <= req_op;
            root_q  <= ppn_t'(satp);
            off_q   <= req_off;
        end

        if (state_q == ST_CHECK && check_done) begin
            if (off_q) begin
                paddr_q <= paddr_t'(vaddr_q);
            end else begin
                paddr_q <= {rd_ppn, vaddr_q[PAGE_OFFSET_W-1:0]};
            end
            fault_q    <= ~off_q & perm_fault;
            fault_op_q <= (~off_q & perm_fault) ? op_q : OP_NONE;
        end else if (state_q == ST_WALK && walk_done) begin
            paddr_q    <= {walk_ppn, vaddr_q[PAGE_OFFSET_W-1:0]};
            fault_q    <= walk_fault;
            fault_op_q <= walk_fault ? op_q : OP_NONE;
        end
    end

    assign resp_valid    = (state_q == ST_RESP);
    assign resp_paddr    = paddr_q;
    assign resp_fault    = fault_q;
    assign resp_fault_op = fault_op_q;

endmodule

`default_nettype wire

// File: design/page_walker.sv
`timescale 1ns/10ps
`default_nettype none

module page_walker
    import dtlb_pkg::*;
#(
    parameter int TLB_DEPTH = 256
) (
    input  wire logic       CLK,
    input  wire logic       RST,

    input  wire logic       walk_start,
    input  wire vaddr_t     walk_vaddr,
    input  wire op_e        walk_op,
    input  wire ppn_t       walk_root,
    output logic            walk_done,
    output logic            walk_fault,
    output ppn_t            walk_ppn,

    // wishbone classic, reads only
    output logic            wb_cyc,
    output logic            wb_stb,
    output paddr_t          wb_adr,
    input  wire pte_t       wb_dat_i,
    input  wire logic       wb_ack,

    tlb_refill_if.walker    refill
);

    localparam int IDX_W = $clog2(TLB_DEPTH);
    localparam int TAG_W = tlb_tag_w(TLB_DEPTH);

    walk_state_e state_q;
    walk_state_e next_level;

    vaddr_t vaddr_q;
    op_e    op_q;
    paddr_t adr_q;
    ppn_t   leaf_ppn_q;
    logic   dirty_q;
    logic   writable_q;
    logic   done_q;
    logic   fault_q;

    ppn_t   pte_ppn;
    logic   pte_v;
    logic   pte_leaf;
    logic   perm_ok;
    vpn_t   next_vpn;
    ppn_t   merged_ppn;
    logic   walking;
    logic   descend;

    always_comb begin
        pte_ppn  = wb_dat_i[PTE_PPN_LSB +: PPN_W];
        pte_v    = wb_dat_i[PTE_V];
        pte_leaf = wb_dat_i[PTE_R] | wb_dat_i[PTE_X];
        perm_ok  = wb_dat_i[PTE_A]
                 & ((op_q != OP_STORE) | (wb_dat_i[PTE_D] & wb_dat_i[PTE_W]));

        // superpages keep the low vpn slices of the request
        case (state_q)
            WALK_L2: merged_ppn = {pte_ppn[PPN_W-1:2*VPN_W],
                                   vpn_slice(vaddr_q, 1), vpn_slice(vaddr_q, 0)};
            WALK_L1: merged_ppn = {pte_ppn[PPN_W-1:VPN_W], vpn_slice(vaddr_q, 0)};
            default: merged_ppn = pte_ppn;
        endcase

        case (state_q)
            WALK_L2: begin
                next_level = WALK_L1;
                next_vpn   = vpn_slice(vaddr_q, 1);
            end
            default: begin
                next_level = WALK_L0;
                next_vpn   = vpn_slice(vaddr_q, 0);
            end
        endcase
    end

    assign walking = (state_q != WALK_IDLE);
    assign descend = walking & wb_ack & pte_v & ~pte_leaf & (state_q != WALK_L0);

    always_ff @(posedge CLK) begin
        if (RST) begin
            state_q <= WALK_IDLE;
            done_q  <= 1'b0;
            fault_q <= 1'b0;
        end else begin
            done_q  <= 1'b0;
            fault_q <= 1'b0;
            if (!walking) begin
                if (walk_start) state_q <= WALK_L2;
            end else if (wb_ack) begin
                if (descend) begin
                    state_q <= next_level;        // cyc stays up, new address
                end else begin
                    state_q <= WALK_IDLE;
                    done_q  <= 1'b1;
                    fault_q <= ~pte_v | ~pte_leaf | ~perm_ok;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (!walking && walk_start) begin
            vaddr_q <= walk_vaddr;
            op_q    <= walk_op;
            adr_q   <= {walk_root, vpn_slice(walk_vaddr, 2), {PTE_SHIFT{1'b0}}};
        end else if (descend) begin
            adr_q   <= {pte_ppn, next_vpn, {PTE_SHIFT{1'b0}}};
        end

        if (walking && wb_ack) begin
            leaf_ppn_q <= merged_ppn;
            dirty_q    <= wb_dat_i[PTE_D];
            writable_q <= wb_dat_i[PTE_W];
        end
    end

    assign wb_cyc = walking;
    assign wb_stb = walking;
    assign wb_adr = adr_q;

    assign walk_done  = done_q;
    assign walk_fault = fault_q;
    assign walk_ppn   = leaf_ppn_q;

    assign refill.wr       = done_q & ~fault_q;   // faults never land in the array
    assign refill.index    = IDX_W'(vpn_of(vaddr_q));
    assign refill.tag      = TAG_W'(vpn_of(vaddr_q) >> IDX_W);
    assign refill.ppn      = leaf_ppn_q;
    assign refill.dirty    = dirty_q;
    assign refill.writable = writable_q;

endmodule

`default_nettype wire

// File: design/dtlb_top.sv
`timescale 1ns/10ps
`default_nettype none

module dtlb_top
    import dtlb_pkg::*;
#(
    parameter int TLB_DEPTH = 256
) (
    input  wire logic   CLK,
    input  wire logic   RST,
    input  wire logic   flush,

    input  wire logic   req_valid,
    output logic        req_ready,
    input  wire vaddr_t req_vaddr,
    input  wire op_e    req_op,
    input  wire satp_t  satp,
    input  wire priv_t  priv,

    output logic        resp_valid,
    input  wire logic   resp_ready,
    output paddr_t      resp_paddr,
    output logic        resp_fault,
    output op_e         resp_fault_op,

    output logic        wb_cyc,
    output logic        wb_stb,
    output paddr_t      wb_adr,
    input  wire pte_t   wb_dat_i,
    input  wire logic   wb_ack
);

    localparam int IDX_W = $clog2(TLB_DEPTH);
    localparam int TAG_W = tlb_tag_w(TLB_DEPTH);

    logic [IDX_W-1:0] rd_index;
    logic [TAG_W-1:0] rd_tag;
    ppn_t             rd_ppn;
    logic             rd_dirty;
    logic             rd_writable;
    logic             rd_valid;

    logic             walk_start;
    vaddr_t           walk_vaddr;
    op_e              walk_op;
    ppn_t             walk_root;
    logic             walk_done;
    logic             walk_fault;
    ppn_t             walk_ppn;

    tlb_refill_if #(.TLB_DEPTH(TLB_DEPTH)) refill_bus ();

    tlb_array #(.TLB_DEPTH(TLB_DEPTH)) u_array (
        .CLK         (CLK),
        .RST         (RST),
        .flush       (flush),
        .rd_index    (rd_index),
        .rd_tag      (rd_tag),
        .rd_ppn      (rd_ppn),
        .rd_dirty    (rd_dirty),
        .rd_writable (rd_writable),
        .rd_valid    (rd_valid),
        .refill      (refill_bus.array)
    );

    translate_stage #(.TLB_DEPTH(TLB_DEPTH)) u_translate (
        .CLK           (CLK),
        .RST           (RST),
        .flush         (flush),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_vaddr     (req_vaddr),
        .req_op        (req_op),
        .satp          (satp),
        .priv          (priv),
        .resp_valid    (resp_valid),
        .resp_ready    (resp_ready),
        .resp_paddr    (resp_paddr),
        .resp_fault    (resp_fault),
        .resp_fault_op (resp_fault_op),
        .rd_index      (rd_index),
        .rd_tag        (rd_tag),
        .rd_ppn        (rd_ppn),
        .rd_dirty      (rd_dirty),
        .rd_writable   (rd_writable),
        .rd_valid      (rd_valid),
        .walk_start    (walk_start),
        .walk_vaddr    (walk_vaddr),
        .walk_op       (walk_op),
        .walk_root     (walk_root),
        .walk_done     (walk_done),
        .walk_fault    (walk_fault),
        .walk_ppn      (walk_ppn)
    );

    page_walker #(.TLB_DEPTH(TLB_DEPTH)) u_walker (
        .CLK        (CLK),
        .RST        (RST),
        .walk_start (walk_start),
        .walk_vaddr (walk_vaddr),
        .walk_op    (walk_op),
        .walk_root  (walk_root),
        .walk_done  (walk_done),
        .walk_fault (walk_fault),
        .walk_ppn   (walk_ppn),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_adr     (wb_adr),
        .wb_dat_i   (wb_dat_i),
        .wb_ack     (wb_ack),
        .refill     (refill_bus.walker)
    );

endmodule

`default_nettype wire

// File: verif/pt_memory_model.sv
`timescale 1ns/10ps
`default_nettype none

module pt_memory_model
    import dtlb_pkg::*;
#(
    parameter int MAX_DELAY = 3       // longest ack wait in clock cycles
) (
    input  wire logic   CLK,
    input  wire logic   RST,
    input  wire logic   cyc,
    input  wire logic   stb,
    input  wire paddr_t adr,
    output pte_t        dat_o,
    output logic        ack
);

    localparam logic [15:0] SEED       = 16'd42922;
    localparam int          DELAY_BITS = $clog2(MAX_DELAY + 1);

    pte_t        mem [paddr_t];   // sparse page-table words, byte addressed
    logic [15:0] lfsr_q;
    int          wait_q;

    // taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    initial begin
        ack   = 1'b0;
        dat_o = '0;
    end

    // slave outputs move on the falling edge
    always @(negedge CLK) begin
        if (RST) begin
            ack    <= 1'b0;
            dat_o  <= '0;
            lfsr_q  = SEED;
            wait_q  = 0;
        end else if (ack) begin
            ack    <= 1'b0;
            wait_q  = 0;
            repeat (DELAY_BITS) begin
                lfsr_q = lfsr_step(lfsr_q);
                wait_q = (wait_q << 1) | lfsr_q[0];
            end
            if (wait_q > MAX_DELAY) wait_q = MAX_DELAY;
        end else if (cyc && stb) begin
            if (wait_q == 0) begin
                ack   <= 1'b1;
                dat_o <= mem.exists(adr) ? mem[adr] : '0;   // unmapped reads as invalid
            end else begin
                wait_q = wait_q - 1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/dtlb_tb.sv
`timescale 1ns/10ps
`default_nettype none

module dtlb_tb
    import dtlb_pkg::*;
();

    localparam int    CLK_PERIOD = 40;
    localparam int    NUM_REQ    = 24;
    localparam int    MAX_DELAY  = 3;
    localparam ppn_t  ROOT_PPN   = 44'h100;
    localparam satp_t SATP_SV39  = {4'd8, 16'h0, ROOT_PPN};
    localparam priv_t PRIV_S     = 2'd1;

    logic   CLK;
    logic   RST;
    logic   flush;
    logic   req_valid;
    logic   req_ready;
    vaddr_t req_vaddr;
    op_e    req_op;
    satp_t  satp;
    priv_t  priv;
    logic   resp_valid;
    logic   resp_ready;
    paddr_t resp_paddr;
    logic   resp_fault;
    op_e    resp_fault_op;
    logic   wb_cyc;
    logic   wb_stb;
    paddr_t wb_adr;
    pte_t   wb_dat_i;
    logic   wb_ack;

    int     errors;
    int     mark;
    int     tests_run;
    paddr_t seen_adr [$];

    dtlb_top #(.TLB_DEPTH(256)) UUT (
        .CLK(CLK), .RST(RST), .flush(flush),
        .req_valid(req_valid), .req_ready(req_ready), .req_vaddr(req_vaddr),
        .req_op(req_op), .satp(satp), .priv(priv),
        .resp_valid(resp_valid), .resp_ready(resp_ready), .resp_paddr(resp_paddr),
        .resp_fault(resp_fault), .resp_fault_op(resp_fault_op),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i), .wb_ack(wb_ack)
    );

    pt_memory_model #(.MAX_DELAY(MAX_DELAY)) mem_model (
        .CLK(CLK), .RST(RST), .cyc(wb_cyc), .stb(wb_stb),
        .adr(wb_adr), .dat_o(wb_dat_i), .ack(wb_ack)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // bus monitor, one entry per completed read
    always @(posedge CLK) begin
        if (wb_stb && wb_ack) seen_adr.push_back(wb_adr);
    end

    task automatic flag_mismatch(string msg);
        errors++;
        $display("FAILED at %0t: %s", $time, msg);
    endtask

    assert property (@(posedge CLK) disable iff (RST)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_paddr) && $stable(resp_fault))
        else flag_mismatch("held response changed");
    assert property (@(posedge CLK) disable iff (RST) resp_valid |-> !req_ready)
        else flag_mismatch("req_ready high while a response is pending");
    assert property (@(posedge CLK) disable iff (RST)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr))
        else flag_mismatch("wishbone read dropped or moved before ack");
    assert property (@(posedge CLK) disable iff (RST) wb_cyc == wb_stb)
        else flag_mismatch("wb_cyc and wb_stb differ");

    function automatic vaddr_t mk_va(vpn_t v2, vpn_t v1, vpn_t v0, logic [11:0] off);
        return {25'h0, v2, v1, v0, off};
    endfunction

    function automatic pte_t read_pte(paddr_t a);
        return mem_model.mem.exists(a) ? mem_model.mem[a] : '0;
    endfunction

    task automatic write_pte(paddr_t a, ppn_t ppn, logic [7:0] flags);
        mem_model.mem[a] = {10'h0, ppn, 2'b00, flags};
    endtask

    // leaf at the given level, pointer tables placed by vpn
    task automatic map_page(vaddr_t va, int level, ppn_t leaf, logic [7:0] flags);
        ppn_t l1_tbl;
        ppn_t l0_tbl;
        l1_tbl = 44'h1000 + va[38:30];
        l0_tbl = 44'h2000 + {va[38:30], va[29:21]};
        if (level == 2) begin
            write_pte({ROOT_PPN, va[38:30], 3'b000}, leaf, flags);
        end else begin
            write_pte({ROOT_PPN, va[38:30], 3'b000}, l1_tbl, 8'h01);
            if (level == 1) begin
                write_pte({l1_tbl, va[29:21], 3'b000}, leaf, flags);
            end else begin
                write_pte({l1_tbl, va[29:21], 3'b000}, l0_tbl, 8'h01);
                write_pte({l0_tbl, va[20:12], 3'b000}, leaf, flags);
            end
        end
    endtask

    // sv39 walk over the tables in the memory model
    task automatic ref_translate(input vaddr_t va, input op_e op, input satp_t sp,
                                 input priv_t pv, output paddr_t pa, output bit flt,
                                 output paddr_t adrs [$]);
        ppn_t   base;
        ppn_t   ppn;
        ppn_t   mask;
        paddr_t a;
        pte_t   pte;
        adrs = {};
        flt  = 1'b0;
        pa   = '0;
        if (op == OP_NONE || sp[63:60] != 4'd8 || pv == 2'd3) begin
            pa = va[55:0];
            return;
        end
        base = sp[43:0];
        for (int lvl = 2; lvl >= 0; lvl--) begin
            a = {base, va[12 + 9 * lvl +: 9], 3'b000};
            adrs.push_back(a);
            pte = read_pte(a);
            if (!pte[0]) begin
                flt = 1'b1;
                return;
            end
            if (pte[1] || pte[3]) begin
                if (!pte[6] || (op == OP_STORE && !(pte[7] && pte[2]))) begin
                    flt = 1'b1;
                    return;
                end
                mask = (ppn_t'(1) << (9 * lvl)) - 1;
                ppn  = (pte[53:10] & ~mask) | (ppn_t'(va >> 12) & mask);
                pa   = {ppn, va[11:0]};
                return;
            end
            base = pte[53:10];
        end
        flt = 1'b1;   // still a pointer at level 0
    endtask

    task automatic run_req(vaddr_t va, op_e op, satp_t sp, priv_t pv, bit walk, int hold);
        paddr_t exp_pa;
        bit     exp_fault;
        paddr_t exp_adrs [$];
        paddr_t held_pa;
        int     lat;
        ref_translate(va, op, sp, pv, exp_pa, exp_fault, exp_adrs);
        req_valid  = 1'b1;
        req_vaddr  = va;
        req_op     = op;
        satp       = sp;
        priv       = pv;
        resp_ready = (hold == 0);
        while (!req_ready) @(negedge CLK);
        seen_adr.delete();
        @(negedge CLK);
        req_valid = 1'b0;
        lat = 1;
        while (!resp_valid) begin
            @(negedge CLK);
            lat++;
        end
        if (hold > 0) begin
            held_pa = resp_paddr;
            repeat (hold) begin
                @(negedge CLK);
                assert (resp_valid && resp_paddr == held_pa && !req_ready)
                    else flag_mismatch("response not held under back-pressure");
            end
            resp_ready = 1'b1;
        end
        assert (resp_fault == exp_fault)
            else flag_mismatch($sformatf("va %h fault %0b, expected %0b",
                                         va, resp_fault, exp_fault));
        if (exp_fault) begin
            assert (resp_fault_op == op)
                else flag_mismatch($sformatf("va %h fault op %0d", va, resp_fault_op));
        end else begin
            assert (resp_paddr == exp_pa)
                else flag_mismatch($sformatf("va %h paddr %h, expected %h",
                                             va, resp_paddr, exp_pa));
        end
        if (walk) begin
            assert (seen_adr.size() == exp_adrs.size())
                else flag_mismatch($sformatf("va %h made %0d reads, expected %0d",
                                             va, seen_adr.size(), exp_adrs.size()));
            foreach (exp_adrs[i]) begin
                if (i < seen_adr.size()) begin
                    assert (seen_adr[i] == exp_adrs[i])
                        else flag_mismatch($sformatf("read %0d at %h, expected %h",
                                                     i, seen_adr[i], exp_adrs[i]));
                end
            end
        end else begin
            assert (seen_adr.size() == 0)
                else flag_mismatch($sformatf("va %h read the bus on a hit", va));
            assert (lat == 2)
                else flag_mismatch($sformatf("va %h response after %0d cycles", va, lat));
        end
        @(negedge CLK);
    endtask

    task automatic pulse_flush();
        flush = 1'b1;
        @(negedge CLK);
        flush = 1'b0;
        @(negedge CLK);
    endtask

    task automatic end_test(string name);
        tests_run++;
        $display("test %0d %s: %s", tests_run, name, (errors == mark) ? "ok" : "errors");
        mark = errors;
    endtask

    initial begin
        #(NUM_REQ * 3 * (MAX_DELAY + 2) * CLK_PERIOD + 400 * CLK_PERIOD);
        $display("watchdog expired, the DUT stopped responding");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        vaddr_t p1;
        vaddr_t p7;
        errors     = 0;
        mark       = 0;
        tests_run  = 0;
        RST        = 1'b1;
        flush      = 1'b0;
        req_valid  = 1'b0;
        req_vaddr  = '0;
        req_op     = OP_NONE;
        satp       = '0;
        priv       = '0;
        resp_ready = 1'b1;
        p1 = mk_va(9'd1, 9'd2, 9'd3, 12'h123);
        p7 = mk_va(9'd5, 9'd2, 9'd3, 12'h456);   // same index as p1, other tag
        map_page(p1, 0, 44'hABCDE, 8'hC7);
        map_page(p7, 0, 44'h7777, 8'hC7);
        map_page(mk_va(9'd2, 0, 0, 0), 2, 44'h5_5555_5555, 8'hC3);
        map_page(mk_va(9'd3, 9'd4, 0, 0), 1, 44'h3_3333_3333, 8'hC7);
        map_page(mk_va(9'd4, 9'd1, 9'd1, 0), 0, 44'h4441, 8'h03);   // A clear
        map_page(mk_va(9'd4, 9'd1, 9'd2, 0), 0, 44'h4442, 8'h47);   // no D
        map_page(mk_va(9'd4, 9'd1, 9'd5, 0), 0, 44'h4445, 8'h01);   // pointer at L0
        repeat (3) @(negedge CLK);
        RST = 1'b0;
        @(negedge CLK);

        run_req(64'hFEDC_BA98_7654_3210, OP_NONE, SATP_SV39, PRIV_S, 0, 0);
        run_req(64'hFEDC_BA98_7654_3210, OP_LOAD, 64'h0, PRIV_S, 0, 0);
        run_req(64'hFEDC_BA98_7654_3210, OP_STORE, SATP_SV39, PRIV_M, 0, 0);
        end_test("bypass");

        run_req(p1, OP_LOAD, SATP_SV39, PRIV_S, 1, 0);
        end_test("4k walk");

        run_req(p1, OP_STORE, SATP_SV39, PRIV_S, 0, 0);
        run_req(mk_va(9'd2, 9'd17, 9'd33, 12'hABC), OP_LOAD, SATP_SV39, PRIV_S, 1, 0);
        run_req(mk_va(9'd3, 9'd4, 9'd77, 12'h010), OP_STORE, SATP_SV39, PRIV_S, 1, 0);
        run_req(mk_va(9'd2, 9'd17, 9'd33, 12'hABC), OP_FETCH, SATP_SV39, PRIV_S, 0, 0);
        end_test("hit and superpages");

        run_req(mk_va(9'd7, 0, 0, 12'h8), OP_LOAD, SATP_SV39, PRIV_S, 1, 0);
        run_req(mk_va(9'd7, 0, 0, 12'h8), OP_LOAD, SATP_SV39, PRIV_S, 1, 0);
        run_req(mk_va(9'd4, 9'd1, 9'd1, 0), OP_LOAD, SATP_SV39, PRIV_S, 1, 0);
        run_req(mk_va(9'd4, 9'd1, 9'd1, 0), OP_LOAD, SATP_SV39, PRIV_S, 1, 0);
        run_req(mk_va(9'd4, 9'd1, 9'd2, 0), OP_STORE, SATP_SV39, PRIV_S, 1, 0);
        run_req(mk_va(9'd4, 9'd1, 9'd2, 0), OP_STORE, SATP_SV39, PRIV_S, 1, 0);
        run_req(mk_va(9'd4, 9'd1, 9'd2, 0), OP_LOAD, SATP_SV39, PRIV_S, 1, 0);
        run_req(mk_va(9'd4, 9'd1, 9'd2, 0), OP_STORE, SATP_SV39, PRIV_S, 0, 0);  // hit, no D
        run_req(mk_va(9'd4, 9'd1, 9'd5, 0), OP_FETCH, SATP_SV39, PRIV_S, 1, 0);
        end_test("faults");

        pulse_flush();
        run_req(p1, OP_LOAD, SATP_SV39, PRIV_S, 1, 0);
        run_req(p7, OP_LOAD, SATP_SV39, PRIV_S, 1, 0);
        run_req(p1, OP_LOAD, SATP_SV39, PRIV_S, 1, 0);
        run_req(p7, OP_LOAD, SATP_SV39, PRIV_S, 1, 0);
        end_test("flush and conflict");

        run_req(p7, OP_LOAD, SATP_SV39, PRIV_S, 0, 5);
        end_test("back-pressure");

        $display("tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
design/dtlb_pkg.sv
design/tlb_refill_if.sv
design/tlb_array.sv
design/translate_stage.sv
design/page_walker.sv
design/dtlb_top.sv
verif/pt_memory_model.sv
verif/dtlb_tb.sv

// File: Bender.yml
package:
  name: dtlb

sources:
  - files:
      - design/dtlb_pkg.sv
      - design/tlb_refill_if.sv
      - design/tlb_array.sv
      - design/translate_stage.sv
      - design/page_walker.sv
      - design/dtlb_top.sv
  - target: test
    files:
      - verif/pt_memory_model.sv
      - verif/dtlb_tb.sv
